// File: verilog/ex_pkg.sv
// Execute stage package with word widths, operator encodings and multiplier state

package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Integer datapath width
  localparam int XLEN = 32;

  // Shift-add iterations, one per multiplier bit
  localparam int MULT_STEPS = 32;

  typedef logic [XLEN-1:0] word_t;

  // Six address bits, upper half of the space is the FP register file
  typedef logic [5:0] reg_addr_t;

  // Iteration counter, wide enough for MULT_STEPS - 1
  typedef logic [4:0] mult_cnt_t;

  ////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////

  // ALU and branch compare operators
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Plain multiply or multiply-accumulate
  typedef enum logic {
    MUL_MUL,
    MUL_MAC
  } mult_op_e;

  // Multiplier FSM
  typedef enum logic {
    MULT_IDLE,
    MULT_BUSY
  } mult_state_e;

endpackage

// File: verilog/ex_mult_if.sv
// Request and response bundle between the execute stage and the multiplier
`timescale 1ns/10ps

interface ex_mult_if;

  // Request, held stable by the stage until it is accepted
  logic             en;
  ex_pkg::mult_op_e op;
  ex_pkg::word_t    op_a;
  ex_pkg::word_t    op_b;
  ex_pkg::word_t    op_c;

  // Response
  ex_pkg::word_t    result;
  logic             ready;

  modport requester (output en, output op, output op_a, output op_b, output op_c,
                     input result, input ready);

  modport unit (input en, input op, input op_a, input op_b, input op_c,
                output result, output ready);

endinterface

// File: verilog/ex_alu.sv
// Single-cycle integer ALU with branch comparator
`timescale 1ns/10ps

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            comparison_result_o
);

  logic [4:0]    shamt;
  logic          is_sub;
  ex_pkg::word_t adder_b;
  ex_pkg::word_t adder_result;
  logic          is_equal;
  logic          lt_signed;
  logic          lt_unsigned;
  logic          cmp;

  ////////////////////////////////////////////////////////////
  // Adder and comparators
  ////////////////////////////////////////////////////////////

  // One adder serves add and sub, B inverted plus carry in
  assign is_sub       = (operator_i == ex_pkg::ALU_SUB);
  assign adder_b      = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_b + ex_pkg::word_t'(is_sub);

  // Shift amount from the low five bits of B
  assign shamt = operand_b_i[4:0];

  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  // Branch condition, only compare operators produce a one
  always_comb begin
    case (operator_i)
      ex_pkg::ALU_EQ:  cmp = is_equal;
      ex_pkg::ALU_NE:  cmp = ~is_equal;
      ex_pkg::ALU_LT:  cmp = lt_signed;
      ex_pkg::ALU_GE:  cmp = ~lt_signed;
      ex_pkg::ALU_LTU: cmp = lt_unsigned;
      ex_pkg::ALU_GEU: cmp = ~lt_unsigned;
      default:         cmp = 1'b0;
    endcase
  end

  assign comparison_result_o = cmp;

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  result_o = adder_result;
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      ex_pkg::ALU_SRA:  result_o = ex_pkg::word_t'($signed(operand_a_i) >>> shamt);
      ex_pkg::ALU_SLT:  result_o = ex_pkg::word_t'(lt_signed);
      ex_pkg::ALU_SLTU: result_o = ex_pkg::word_t'(lt_unsigned);
      // Compare operators return the branch bit zero-extended
      default:          result_o = ex_pkg::word_t'(cmp);
    endcase
  end

  // Decoder in ID must never hand over an undefined operator
  always_comb begin
    assert (!$isunknown(operator_i));
  end

endmodule

// File: verilog/ex_mult.sv
// Iterative shift-add multiplier for MUL and MAC, one bit per cycle
`timescale 1ns/10ps

module ex_mult (
  input logic     clk,
  input logic     rst_n,
  input logic     ex_ready_i,
  ex_mult_if.unit mult
);

  ex_pkg::mult_state_e state_q;
  ex_pkg::mult_cnt_t   cnt_q;
  logic                done_q;
  logic                start;
  logic                last_step;
  ex_pkg::word_t       mcand_q;
  ex_pkg::word_t       mplier_q;
  ex_pkg::word_t       acc_q;

  // New request only when idle and no finished result is still waiting
  assign start     = (state_q == ex_pkg::MULT_IDLE) && mult.en && !done_q;
  assign last_step = (cnt_q == ex_pkg::mult_cnt_t'(ex_pkg::MULT_STEPS - 1));

  // Ready drops in the same cycle the request arrives
  assign mult.ready  = (state_q == ex_pkg::MULT_IDLE) && !start;
  assign mult.result = acc_q;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MULT_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else if (state_q == ex_pkg::MULT_IDLE) begin
      if (start) begin
        state_q <= ex_pkg::MULT_BUSY;
        cnt_q   <= '0;
      end else if (done_q && ex_ready_i) begin
        // Stage took the result, next en is a fresh instruction
        done_q <= 1'b0;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
      if (last_step) begin
        state_q <= ex_pkg::MULT_IDLE;
        done_q  <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Only the low word is kept, so a 32-bit multiplicand is enough
  always_ff @(posedge clk) begin
    if (start) begin
      mcand_q  <= mult.op_a;
      mplier_q <= mult.op_b;
      acc_q    <= (mult.op == ex_pkg::MUL_MAC) ? mult.op_c : '0;
    end else if (state_q == ex_pkg::MULT_BUSY) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Requester keeps the operands steady while we iterate
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ex_pkg::MULT_BUSY) |->
      ($stable(mult.op_a) && $stable(mult.op_b) && $stable(mult.op_c) && $stable(mult.op)));

  // Fixed latency back to ready
  assert property (@(posedge clk) disable iff (!rst_n)
    start |-> ##(ex_pkg::MULT_STEPS + 1) mult.ready);

endmodule

// File: verilog/ex_writeback.sv
// Forwarding mux, EX/WB register for the load/store port and stage stall control
`timescale 1ns/10ps

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,

  // Result sources
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  ex_pkg::word_t     lsu_rdata_i,

  // Unit enables and ready
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  logic              mult_ready_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,

  // Write requests from ID
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  // Forwarding port
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,

  // Load/store write port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,

  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic              we_lsu_q;
  ex_pkg::reg_addr_t waddr_lsu_q;
  logic              lsu_we;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Multiplier wins over CSR, ALU is the fallback
  assign regfile_alu_wdata_fw_o = mult_en_i    ? mult_result_i :
                                  csr_access_i ? csr_rdata_i   :
                                                 alu_result_i;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  // Faulting accesses never reach the register file
  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_lsu_q <= lsu_we;
    end else if (wb_ready_i) begin
      // WB drained its slot and nothing new arrived
      we_lsu_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && lsu_we) begin
      waddr_lsu_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_lsu_q;
  assign regfile_waddr_wb_o = waddr_lsu_q;
  // Load data arrives from the LSU in the WB cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Branches resolve in EX, so they may leave even when WB stalls
  assign ex_ready_o = (mult_ready_i & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & (mult_ready_i & lsu_ready_ex_i & wb_ready_i);

  // No new write may enter WB while it back-pressures
  assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> !$rose(regfile_we_wb_o));

endmodule

// File: verilog/ex_stage.sv
// Execute stage top with ALU, iterative multiplier and writeback control
`timescale 1ns/10ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,

  // ALU from ID
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  input  logic              alu_en_i,

  // Multiplier from ID
  input  ex_pkg::mult_op_e  mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  input  ex_pkg::word_t     mult_operand_c_i,
  input  logic              mult_en_i,
  output logic              mult_multicycle_o,

  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,

  input  logic              branch_in_ex_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_alu_we_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,

  // Load/store write port towards WB
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,

  // Forwarding to ID and register file
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,

  // Branch outcome to IF
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,

  // Stall control
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  output logic              ex_ready_o,
  output logic              ex_valid_o,
  input  logic              wb_ready_i
);

  ex_pkg::word_t alu_result;
  logic          alu_cmp_result;

  ex_mult_if mult_bus ();

  ////////////////////////////////////////////////////////////
  // ALU and branch
  ////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  assign branch_decision_o = alu_cmp_result;
  // Target was computed in ID and rides along as operand C
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  assign mult_bus.en   = mult_en_i;
  assign mult_bus.op   = mult_operator_i;
  assign mult_bus.op_a = mult_operand_a_i;
  assign mult_bus.op_b = mult_operand_b_i;
  assign mult_bus.op_c = mult_operand_c_i;

  ex_mult mult_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_ready_i (ex_ready_o),
    .mult       (mult_bus.unit)
  );

  assign mult_multicycle_o = ~mult_bus.ready;

  ////////////////////////////////////////////////////////////
  // Writeback and stall control
  ////////////////////////////////////////////////////////////

  ex_writeback wb_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_bus.result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .mult_ready_i           (mult_bus.ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// File: include/tb_ex_ref.svh
// Reference models for ALU, branch compare and multiplier results of the execute stage
`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

// Branch condition where only compare operators can be true
function automatic logic branch_taken(input ex_pkg::alu_op_e op, input logic [31:0] a,
                                      input logic [31:0] b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  sa = a;
  sb = b;
  case (op)
    ex_pkg::ALU_EQ:  return a == b;
    ex_pkg::ALU_NE:  return a != b;
    ex_pkg::ALU_LT:  return sa < sb;
    ex_pkg::ALU_GE:  return sa >= sb;
    ex_pkg::ALU_LTU: return a < b;
    ex_pkg::ALU_GEU: return a >= b;
    default:         return 1'b0;
  endcase
endfunction

// Expected ALU result with shifts by the low five bits of B
function automatic logic [31:0] alu_outcome(input ex_pkg::alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  logic signed [31:0] sra;
  int unsigned        sh;
  sa  = a;
  sb  = b;
  sh  = b % 32;
  sra = sa >>> sh;
  case (op)
    ex_pkg::ALU_ADD:  return a + b;
    ex_pkg::ALU_SUB:  return a - b;
    ex_pkg::ALU_AND:  return a & b;
    ex_pkg::ALU_OR:   return a | b;
    ex_pkg::ALU_XOR:  return a ^ b;
    ex_pkg::ALU_SLL:  return a << sh;
    ex_pkg::ALU_SRL:  return a >> sh;
    ex_pkg::ALU_SRA:  return sra;
    ex_pkg::ALU_SLT:  return {31'b0, sa < sb};
    ex_pkg::ALU_SLTU: return {31'b0, a < b};
    // Compares hand back the branch bit
    default:          return {31'b0, branch_taken(op, a, b)};
  endcase
endfunction

// Low word of the full product plus C for MAC
function automatic logic [31:0] product_low_word(input ex_pkg::mult_op_e op,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b,
                                                 input logic [31:0] c);
  logic [63:0] full;
  full = {32'b0, a} * {32'b0, b};
  if (op == ex_pkg::MUL_MAC) begin
    return full[31:0] + c;
  end
  return full[31:0];
endfunction

`endif

// File: sim/tb_ex_stage.sv
// Testbench for the execute stage with ALU, branch, multiplier and writeback checks
`timescale 1ns/10ps

module tb_ex_stage;

  localparam int unsigned SEED         = 32'hf6ac5f69;
  localparam int          MULT_TIMEOUT = 2 * ex_pkg::MULT_STEPS + 8;

  logic              clk;
  logic              rst_n;
  ex_pkg::alu_op_e   alu_operator_i;
  ex_pkg::word_t     alu_operand_a_i;
  ex_pkg::word_t     alu_operand_b_i;
  ex_pkg::word_t     alu_operand_c_i;
  logic              alu_en_i;
  ex_pkg::mult_op_e  mult_operator_i;
  ex_pkg::word_t     mult_operand_a_i;
  ex_pkg::word_t     mult_operand_b_i;
  ex_pkg::word_t     mult_operand_c_i;
  logic              mult_en_i;
  logic              mult_multicycle_o;
  logic              lsu_en_i;
  ex_pkg::word_t     lsu_rdata_i;
  logic              branch_in_ex_i;
  ex_pkg::reg_addr_t regfile_alu_waddr_i;
  logic              regfile_alu_we_i;
  logic              regfile_we_i;
  ex_pkg::reg_addr_t regfile_waddr_i;
  logic              csr_access_i;
  ex_pkg::word_t     csr_rdata_i;
  ex_pkg::reg_addr_t regfile_waddr_wb_o;
  logic              regfile_we_wb_o;
  ex_pkg::word_t     regfile_wdata_wb_o;
  ex_pkg::reg_addr_t regfile_alu_waddr_fw_o;
  logic              regfile_alu_we_fw_o;
  ex_pkg::word_t     regfile_alu_wdata_fw_o;
  ex_pkg::word_t     jump_target_o;
  logic              branch_decision_o;
  logic              lsu_ready_ex_i;
  logic              lsu_err_i;
  logic              ex_ready_o;
  logic              ex_valid_o;
  logic              wb_ready_i;

  // Expected values for the compare process
  logic              fw_armed;
  logic [31:0]       fw_expected;
  logic              br_armed;
  logic              br_expected;

  `include "tb_ex_ref.svh"

  ex_stage ex_stage_i (.*);

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s did not arrive within %0d cycles",
             $time, what, MULT_TIMEOUT);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped on timeout");
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (fw_armed) begin
      check_value("forwarded data", regfile_alu_wdata_fw_o, fw_expected);
    end
    if (br_armed) begin
      check_value("branch decision", 32'(branch_decision_o), 32'(br_expected));
    end
  end

  // Inputs change shortly after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic idle_inputs();
    alu_en_i         = 1'b0;
    mult_en_i        = 1'b0;
    lsu_en_i         = 1'b0;
    csr_access_i     = 1'b0;
    branch_in_ex_i   = 1'b0;
    regfile_alu_we_i = 1'b0;
    regfile_we_i     = 1'b0;
    lsu_err_i        = 1'b0;
    lsu_ready_ex_i   = 1'b1;
    wb_ready_i       = 1'b1;
    fw_armed         = 1'b0;
    br_armed         = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////////////////////////

  // Every operator with the last pass on equal operands
  task automatic exercise_alu();
    ex_pkg::reg_addr_t addr;
    logic              we;
    int                i;
    int                n;
    for (i = 0; i < 16; i++) begin
      for (n = 0; n < 4; n++) begin
        next_cycle();
        addr                = ex_pkg::reg_addr_t'($urandom);
        we                  = 1'($urandom);
        alu_operator_i      = ex_pkg::alu_op_e'(i);
        alu_operand_a_i     = $urandom;
        alu_operand_b_i     = (n == 3) ? alu_operand_a_i : $urandom;
        alu_en_i            = 1'b1;
        regfile_alu_we_i    = we;
        regfile_alu_waddr_i = addr;
        fw_expected         = alu_outcome(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
        fw_armed            = 1'b1;
        @(negedge clk);
        check_value("forwarded address", 32'(regfile_alu_waddr_fw_o), 32'(addr));
        check_value("forwarded enable", 32'(regfile_alu_we_fw_o), 32'(we));
      end
    end
    next_cycle();
    idle_inputs();
  endtask

  // Branch leaves EX even when WB stalls
  task automatic branch_cases();
    int i;
    int n;
    for (i = int'(ex_pkg::ALU_EQ); i <= int'(ex_pkg::ALU_GEU); i++) begin
      for (n = 0; n < 2; n++) begin
        next_cycle();
        alu_operator_i  = ex_pkg::alu_op_e'(i);
        alu_operand_a_i = $urandom;
        alu_operand_b_i = (n == 1) ? alu_operand_a_i : $urandom;
        alu_operand_c_i = $urandom;
        branch_in_ex_i  = 1'b1;
        wb_ready_i      = (n == 0);
        br_expected     = branch_taken(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
        br_armed        = 1'b1;
        @(negedge clk);
        check_value("jump target", jump_target_o, alu_operand_c_i);
        check_value("ex_ready_o on branch", 32'(ex_ready_o), 32'd1);
      end
    end
    next_cycle();
    idle_inputs();
  endtask

  task automatic mult_case(input ex_pkg::mult_op_e op);
    logic [31:0] expected;
    logic        saw_busy;
    int          waited;
    next_cycle();
    mult_operator_i  = op;
    mult_operand_a_i = $urandom;
    mult_operand_b_i = $urandom;
    mult_operand_c_i = $urandom;
    mult_en_i        = 1'b1;
    regfile_alu_we_i = 1'b1;
    expected         = product_low_word(op, mult_operand_a_i, mult_operand_b_i,
                                        mult_operand_c_i);
    saw_busy         = 1'b0;
    waited           = 0;
    @(negedge clk);
    while (!ex_ready_o) begin
      if (mult_multicycle_o) begin
        saw_busy = 1'b1;
      end
      if (waited >= MULT_TIMEOUT) begin
        report_timeout("multiplier result");
      end
      waited++;
      @(negedge clk);
    end
    check_value("multicycle flag before result", 32'(saw_busy), 32'd1);
    check_value("multiplier result", regfile_alu_wdata_fw_o, expected);
    // Stage accepts the result on this edge
    next_cycle();
    idle_inputs();
  endtask

  task automatic csr_forwarding();
    int n;
    for (n = 0; n < 3; n++) begin
      next_cycle();
      alu_operator_i  = ex_pkg::ALU_ADD;
      alu_operand_a_i = $urandom;
      alu_operand_b_i = $urandom;
      alu_en_i        = 1'b1;
      csr_access_i    = 1'b1;
      csr_rdata_i     = $urandom;
      fw_expected     = csr_rdata_i;
      fw_armed        = 1'b1;
      @(negedge clk);
    end
    next_cycle();
    idle_inputs();
  endtask

  task automatic lsu_write_port();
    ex_pkg::reg_addr_t addr;
    int                n;
    for (n = 0; n < 3; n++) begin
      next_cycle();
      addr            = ex_pkg::reg_addr_t'($urandom);
      lsu_en_i        = 1'b1;
      regfile_we_i    = 1'b1;
      regfile_waddr_i = addr;
      @(negedge clk);
      check_value("ex_valid_o on load", 32'(ex_valid_o), 32'd1);
      next_cycle();
      idle_inputs();
      lsu_rdata_i = $urandom;
      @(negedge clk);
      check_value("write enable one cycle later", 32'(regfile_we_wb_o), 32'd1);
      check_value("write address", 32'(regfile_waddr_wb_o), 32'(addr));
      check_value("write data", regfile_wdata_wb_o, lsu_rdata_i);
      next_cycle();
      @(negedge clk);
      check_value("write enable cleared", 32'(regfile_we_wb_o), 32'd0);
    end
    // Faulting access
    next_cycle();
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    lsu_err_i       = 1'b1;
    regfile_waddr_i = ex_pkg::reg_addr_t'($urandom);
    next_cycle();
    idle_inputs();
    @(negedge clk);
    check_value("write enable on error", 32'(regfile_we_wb_o), 32'd0);
  endtask

  task automatic back_pressure();
    ex_pkg::reg_addr_t addr;
    int                n;
    next_cycle();
    addr            = ex_pkg::reg_addr_t'($urandom);
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = addr;
    next_cycle();
    // WB stalls while a second load waits in EX
    wb_ready_i      = 1'b0;
    regfile_waddr_i = ~addr;
    for (n = 0; n < 2; n++) begin
      @(negedge clk);
      check_value("ex_ready_o under stall", 32'(ex_ready_o), 32'd0);
      check_value("ex_valid_o under stall", 32'(ex_valid_o), 32'd0);
      check_value("held write enable", 32'(regfile_we_wb_o), 32'd1);
      check_value("held write address", 32'(regfile_waddr_wb_o), 32'(addr));
      next_cycle();
    end
    // LSU not ready blocks the stage as well
    wb_ready_i     = 1'b1;
    lsu_ready_ex_i = 1'b0;
    @(negedge clk);
    check_value("ex_ready_o with LSU busy", 32'(ex_ready_o), 32'd0);
    check_value("ex_valid_o with LSU busy", 32'(ex_valid_o), 32'd0);
    next_cycle();
    idle_inputs();
    @(negedge clk);
    check_value("write enable after drain", 32'(regfile_we_wb_o), 32'd0);
    check_value("ex_ready_o after drain", 32'(ex_ready_o), 32'd1);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    clk                 = 1'b0;
    rst_n               = 1'b0;
    alu_operator_i      = ex_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_operator_i     = ex_pkg::MUL_MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_operand_c_i    = '0;
    lsu_rdata_i         = '0;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
    csr_rdata_i         = '0;
    fw_expected         = '0;
    br_expected         = 1'b0;
    idle_inputs();

    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("write enable after reset", 32'(regfile_we_wb_o), 32'd0);
    check_value("multiplier idle after reset", 32'(mult_multicycle_o), 32'd0);

    exercise_alu();
    branch_cases();
    repeat (4) mult_case(ex_pkg::MUL_MUL);
    repeat (4) mult_case(ex_pkg::MUL_MAC);
    csr_forwarding();
    lsu_write_port();
    back_pressure();

    next_cycle();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
verilog/ex_pkg.sv
verilog/ex_mult_if.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
sim/tb_ex_stage.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
